/* Makefile */
VERILATOR ?= verilator
TOP       ?= serial_link_tb
FILELIST  ?= serial_link.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* rtl/frame_rx.sv */
`timescale 1ns/1ns

module frame_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  serial_link_pkg::link_cfg_t cfg_q,
    input  logic                       line_in,
    output serial_link_pkg::rx_word_t  rx
);

    serial_link_pkg::rx_state_e        state;
    logic [serial_link_pkg::DIV_W-1:0] smp_cnt;  // clocks to next sample
    logic [2:0]                        bit_idx;
    logic [7:0]                        sipo;
    logic                              sync_meta;
    logic                              sync_q;
    logic                              line_prev;
    logic                              fall;
    logic                              sample;
    logic                              valid_q;
    logic                              err_q;
    logic [7:0]                        data_q;

    // ------------------------------
    // input synchronizer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_meta <= 1'b1;  // idle level
            sync_q    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_meta <= line_in;
            sync_q    <= sync_meta;
            line_prev <= sync_q;
        end
    end

    assign fall   = line_prev && !sync_q;
    assign sample = (smp_cnt == '0);

    // ------------------------------
    // sampling state machine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= serial_link_pkg::R_IDLE;
            smp_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                serial_link_pkg::R_IDLE: begin
                    if (fall) begin
                        state   <= serial_link_pkg::R_START;
                        smp_cnt <= cfg_q.div >> 1;  // half a bit
                    end
                end
                serial_link_pkg::R_START: begin
                    if (!sample) begin
                        smp_cnt <= smp_cnt - 1'b1;
                    end else if (sync_q) begin
                        state <= serial_link_pkg::R_IDLE;  // glitch
                    end else begin
                        state   <= serial_link_pkg::R_DATA;
                        smp_cnt <= cfg_q.div;
                        bit_idx <= '0;
                    end
                end
                serial_link_pkg::R_DATA: begin
                    if (!sample) begin
                        smp_cnt <= smp_cnt - 1'b1;
                    end else begin
                        smp_cnt <= cfg_q.div;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= serial_link_pkg::R_STOP;
                    end
                end
                default: begin
                    if (!sample) begin
                        smp_cnt <= smp_cnt - 1'b1;
                    end else begin
                        state   <= serial_link_pkg::R_IDLE;
                        valid_q <= 1'b1;  // pulse after stop sample
                    end
                end
            endcase
        end
    end

    // sipo and output word
    always_ff @(posedge clk) begin
        if (state == serial_link_pkg::R_DATA && sample)
            sipo <= cfg_q.msb_first ? {sipo[6:0], sync_q} : {sync_q, sipo[7:1]};
        if (state == serial_link_pkg::R_STOP && sample) begin
            data_q <= sipo;
            err_q  <= !sync_q;  // stop bit must be high
        end
    end

    assign rx = '{data: data_q, frame_error: err_q, valid: valid_q};

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        rx.valid |=> !rx.valid);

endmodule

/* rtl/frame_tx.sv */
`timescale 1ns/1ns

module frame_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  serial_link_pkg::link_cfg_t cfg_q,
    input  logic [7:0]                 tx_data,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    output logic                       line_out
);

    serial_link_pkg::tx_state_e        state;
    logic [serial_link_pkg::DIV_W-1:0] bit_cnt;     // clocks left in bit
    logic [2:0]                        bit_idx;
    logic [7:0]                        shreg;
    logic                              ready_r;
    logic                              line_r;
    logic                              accept;
    logic                              bit_end;
    logic                              shift_en;
    logic                              next_bit;
    logic [7:0]                        shreg_next;

    assign accept   = tx_valid && ready_r;
    assign bit_end  = (bit_cnt == '0);
    assign shift_en = bit_end && ((state == serial_link_pkg::START) ||
                      (state == serial_link_pkg::DATA && bit_idx != 3'd7));

    assign next_bit   = cfg_q.msb_first ? shreg[7] : shreg[0];
    assign shreg_next = cfg_q.msb_first ? {shreg[6:0], 1'b0} : {1'b0, shreg[7:1]};

    // ------------------------------
    // frame sequencing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= serial_link_pkg::IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            ready_r <= 1'b1;
            line_r  <= 1'b1;  // line idles high
        end else begin
            if (state == serial_link_pkg::IDLE) begin
                if (accept) begin
                    state   <= serial_link_pkg::START;
                    bit_cnt <= cfg_q.div;
                    ready_r <= 1'b0;
                    line_r  <= 1'b0;  // start bit
                end
            end else if (bit_end) begin
                bit_cnt <= cfg_q.div;
                case (state)
                    serial_link_pkg::START: begin
                        state   <= serial_link_pkg::DATA;
                        bit_idx <= '0;
                        line_r  <= next_bit;
                    end
                    serial_link_pkg::DATA: begin
                        if (bit_idx == 3'd7) begin
                            state  <= serial_link_pkg::STOP;
                            line_r <= 1'b1;  // stop bit
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            line_r  <= next_bit;
                        end
                    end
                    default: begin
                        state   <= serial_link_pkg::IDLE;  // stop bit done
                        ready_r <= 1'b1;
                    end
                endcase
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // piso shift register
    always_ff @(posedge clk) begin
        if (state == serial_link_pkg::IDLE && accept)
            shreg <= tx_data;
        else if (shift_en)
            shreg <= shreg_next;
    end

    assign tx_ready = ready_r;
    assign line_out = line_r;

    a_busy_not_ready: assert property (@(posedge clk) disable iff (rst)
        state != serial_link_pkg::IDLE |-> !tx_ready);

endmodule

/* rtl/link_config.sv */
`timescale 1ns/1ns

module link_config #(
    parameter logic [serial_link_pkg::DIV_W-1:0] RESET_DIV       = 3,
    parameter logic                              RESET_MSB_FIRST = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  serial_link_pkg::cfg_wr_t   cfg,
    output serial_link_pkg::link_cfg_t cfg_q
);

    serial_link_pkg::link_cfg_t cfg_r;
    serial_link_pkg::link_cfg_t cfg_next;

    // ------------------------------
    // write decode
    always_comb begin
        cfg_next = cfg_r;  // hold by default
        if (cfg.valid) begin
            case (cfg.op)
                serial_link_pkg::CFG_SET_DIV: begin
                    cfg_next.div = cfg.value;
                end
                serial_link_pkg::CFG_SET_ORDER: begin
                    cfg_next.msb_first = cfg.value[0];  // lsb of value only
                end
                default: begin
                    cfg_next = cfg_r;  // nop
                end
            endcase
        end
    end

    // ------------------------------
    // config register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_r.div       <= RESET_DIV;
            cfg_r.msb_first <= RESET_MSB_FIRST;
        end else begin
            cfg_r <= cfg_next;  // visible next cycle
        end
    end

    assign cfg_q = cfg_r;

    // ------------------------------
    // write checks
    a_cfg_op_known: assert property (@(posedge clk) disable iff (rst)
        cfg.valid |-> cfg.op inside {serial_link_pkg::CFG_NOP,
                                     serial_link_pkg::CFG_SET_DIV,
                                     serial_link_pkg::CFG_SET_ORDER});

    // a one-clock bit has no middle for the receiver to sample
    a_cfg_div_nonzero: assert property (@(posedge clk) disable iff (rst)
        (cfg.valid && cfg.op == serial_link_pkg::CFG_SET_DIV) |-> cfg.value != '0);

endmodule

/* rtl/serial_link.sv */
`timescale 1ns/1ns

module serial_link #(
    parameter logic [serial_link_pkg::DIV_W-1:0] RESET_DIV       = 3,
    parameter logic                              RESET_MSB_FIRST = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  serial_link_pkg::cfg_wr_t  cfg,
    input  logic [7:0]                tx_data,
    input  logic                      tx_valid,
    output logic                      tx_ready,
    output logic                      line_out,
    input  logic                      line_in,
    output serial_link_pkg::rx_word_t rx
);

    serial_link_pkg::link_cfg_t cfg_q;  // shared by both sides

    // ------------------------------
    // configuration
    link_config #(
        .RESET_DIV       (RESET_DIV),
        .RESET_MSB_FIRST (RESET_MSB_FIRST)
    ) link_config_inst (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .cfg_q (cfg_q)
    );

    // ------------------------------
    // transmit side
    frame_tx frame_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg_q    (cfg_q),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .line_out (line_out)
    );

    // ------------------------------
    // receive side
    frame_rx frame_rx_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg_q   (cfg_q),
        .line_in (line_in),  // async to clk
        .rx      (rx)
    );

endmodule

/* rtl/serial_link_pkg.sv */
package serial_link_pkg;

    localparam int DIV_W = 16;  // divisor width

    // current link settings, read by both sides
    typedef struct packed {
        logic [DIV_W-1:0] div;        // one bit lasts div+1 clocks
        logic             msb_first;  // 0 = bit 0 first
    } link_cfg_t;

    typedef enum logic [1:0] {
        CFG_NOP,
        CFG_SET_DIV,
        CFG_SET_ORDER
    } cfg_op_e;

    typedef struct packed {
        cfg_op_e          op;
        logic [DIV_W-1:0] value;  // only bit 0 for order
        logic             valid;
    } cfg_wr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       frame_error;  // stop bit seen low
        logic       valid;        // single-cycle pulse
    } rx_word_t;

    // ------------------------------
    // state encodings
    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;
    typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_e;

endpackage

/* serial_link.f */
rtl/serial_link_pkg.sv
rtl/link_config.sv
rtl/frame_tx.sv
rtl/frame_rx.sv
rtl/serial_link.sv
test/serial_link_tb.sv

/* test/serial_link_tb.sv */
`timescale 1ns/1ns

module serial_link_tb;

    logic                      clk;
    logic                      rst;
    serial_link_pkg::cfg_wr_t  cfg;
    logic [7:0]                tx_data;
    logic                      tx_valid;
    logic                      tx_ready;
    logic                      line_out;
    logic                      line_in;
    serial_link_pkg::rx_word_t rx;
    logic                      break_line;     // pulls line_in low
    logic                      check_msb;
    logic                      check_div9;
    logic                      started;        // first byte accepted
    logic                      accept;
    logic [8:0]                sb_mem [0:63];  // {frame_error, data}
    logic [5:0]                sb_wr;
    logic [5:0]                sb_rd;
    logic [8:0]                exp_word;
    logic [7:0]                sent_byte;
    int                        busy_len;       // cycles with tx_ready low
    int                        cur_div;
    integer                    seed;

    assign line_in  = break_line ? 1'b0 : line_out;  // loopback
    assign accept   = tx_valid && tx_ready;
    assign exp_word = sb_mem[sb_rd];

    serial_link #(.RESET_DIV(16'd3), .RESET_MSB_FIRST(1'b0)) serial_link_inst (
        .clk(clk), .rst(rst), .cfg(cfg), .tx_data(tx_data), .tx_valid(tx_valid),
        .tx_ready(tx_ready), .line_out(line_out), .line_in(line_in), .rx(rx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // failure reporting
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] exp);
        $display("[FAIL] %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("%0t %s", $time, msg);
        abort_run();
    endtask

    // ------------------------------
    // stimulus helpers
    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int frame_limit();
        return 12 * (cur_div + 1);  // frame plus margin
    endfunction

    task automatic write_cfg(input serial_link_pkg::cfg_op_e op, input logic [15:0] value);
        cfg <= '{op: op, value: value, valid: 1'b1};
        @(posedge clk);
        cfg <= '{op: serial_link_pkg::CFG_NOP, value: 16'd0, valid: 1'b0};
        @(posedge clk);
    endtask

    // leaves tx_valid high and returns on the acceptance edge
    task automatic send_byte(input logic [7:0] b);
        int t;
        t = 0;
        tx_data  <= b;
        tx_valid <= 1'b1;
        do begin
            @(posedge clk);
            t++;
            if (t > frame_limit())
                report_error("timed out waiting for tx_ready to accept a byte");
        end while (!tx_ready);
    endtask

    task automatic drain_scoreboard();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > frame_limit())
                report_error("timed out waiting for rx.valid");
        end while (sb_rd != sb_wr);
    endtask

    task automatic await_tx_ready();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > frame_limit())
                report_error("timed out waiting for the transmitter to go idle");
        end while (!tx_ready);
    endtask

    task automatic loop_byte(input logic [7:0] b);
        send_byte(b);
        tx_valid <= 1'b0;
        drain_scoreboard();
    endtask

    // ------------------------------
    // scoreboard and monitors
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            sb_wr    <= '0;
            sb_rd    <= '0;
            started  <= 1'b0;
            busy_len <= 0;
        end else begin
            if (accept) begin
                sb_wr    <= sb_wr + 6'd1;
                started  <= 1'b1;
                busy_len <= 0;
            end else if (!tx_ready) begin
                busy_len <= busy_len + 1;
            end
            if (rx.valid)
                sb_rd <= sb_rd + 6'd1;  // pop head
        end
    end

    always @(posedge clk) begin
        if (accept) begin
            sb_mem[sb_wr] <= break_line ? 9'h100 : {1'b0, tx_data};  // broken frame reads 0
            sent_byte     <= tx_data;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> (line_out && tx_ready && !rx.valid))
        else report_error("link was not idle before the first byte");

    a_rx_expected: assert property (@(posedge clk) disable iff (rst)
        rx.valid |-> sb_rd != sb_wr)
        else report_error("rx.valid pulsed with no byte outstanding");

    a_rx_data: assert property (@(posedge clk) disable iff (rst)
        rx.valid |-> rx.data == exp_word[7:0])
        else value_mismatch("rx.data", $sampled(rx.data), $sampled(exp_word[7:0]));

    a_rx_error: assert property (@(posedge clk) disable iff (rst)
        rx.valid |-> rx.frame_error == exp_word[8])
        else value_mismatch("rx.frame_error", {7'd0, $sampled(rx.frame_error)},
                            {7'd0, $sampled(exp_word[8])});

    a_ready_drops: assert property (@(posedge clk) disable iff (rst)
        accept |=> !tx_ready)
        else report_error("tx_ready stayed high after a byte was accepted");

    a_busy_length: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_ready) |-> busy_len == 10 * (cur_div + 1))
        else report_error("tx_ready was not low for exactly ten bit times of a frame");

    // start holds 4 samples at div 3 so ##5 lands mid first data bit
    a_msb_first_bit: assert property (@(posedge clk) disable iff (rst)
        (check_msb && $fell(line_out) && $past(accept)) |-> ##5 line_out == sent_byte[7])
        else value_mismatch("line_out", {7'd0, $sampled(line_out)},
                            {7'd0, $sampled(sent_byte[7])});

    a_start_length: assert property (@(posedge clk) disable iff (rst)
        (check_div9 && $fell(line_out) && $past(accept)) |->
            ##9 !line_out ##1 line_out == sent_byte[7])
        else report_error("start bit did not last 10 cycles at divisor 9");

    // ------------------------------
    // test sequence
    initial begin
        rst        = 1'b1;
        cfg        = '0;
        tx_data    = '0;
        tx_valid   = 1'b0;
        break_line = 1'b0;
        check_msb  = 1'b0;
        check_div9 = 1'b0;
        cur_div    = 3;
        seed       = 32'hf26c;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);  // idle line first

        repeat (20) loop_byte(random_byte());

        write_cfg(serial_link_pkg::CFG_SET_ORDER, 16'd1);
        check_msb <= 1'b1;
        repeat (8) loop_byte(random_byte());

        check_msb <= 1'b0;
        write_cfg(serial_link_pkg::CFG_SET_DIV, 16'd9);
        cur_div    <= 9;
        check_div9 <= 1'b1;
        repeat (10) loop_byte(random_byte());

        repeat (6) send_byte(random_byte());  // valid held across bytes
        tx_valid <= 1'b0;
        drain_scoreboard();

        break_line <= 1'b1;
        send_byte(random_byte());
        tx_valid <= 1'b0;
        drain_scoreboard();
        await_tx_ready();
        break_line <= 1'b0;
        repeat (4) @(posedge clk);
        loop_byte(random_byte());

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
